//--- rtl/sbus_pkg.sv
`default_nettype none

package sbus_pkg;

    // word and memory geometry
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_DEPTH = 2000;
    localparam int ADDR_WIDTH = $clog2(ADDR_DEPTH);

    // control frame layout
    localparam int SID_WIDTH = 2;
    localparam int START_WIDTH = 3;
    localparam int CTRL_BITS = START_WIDTH + SID_WIDTH + 2 + ADDR_WIDTH;

    // one counter covers both the frame and a data word
    localparam int CNT_WIDTH = $clog2(DATA_WIDTH + 1);

    localparam logic [START_WIDTH-1:0] START_PATTERN = 3'b111;

    // frame fields, first bit on the wire at the top
    typedef struct packed {
        logic [START_WIDTH-1:0] start;
        logic [SID_WIDTH-1:0]   sid;
        logic                   write;
        logic                   burst;
        logic [ADDR_WIDTH-1:0]  addr;
    } sbus_hdr_fields_t;

    // shifted in as raw bits, decoded through f
    typedef union packed {
        logic [CTRL_BITS-1:0] raw;
        sbus_hdr_fields_t     f;
    } sbus_hdr_t;

    // datapath strobes and word address from the FSM
    typedef struct packed {
        logic                  load_rd;
        logic                  shift_rd;
        logic                  shift_wr;
        logic                  mem_we;
        logic [ADDR_WIDTH-1:0] addr;
    } sbus_dp_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/sbus_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_frame_rx (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              control,
    input  wire logic              frame_en,
    output sbus_pkg::sbus_hdr_t    hdr
);

    import sbus_pkg::*;

    sbus_hdr_t hdr_q;

    // msb arrives first, so every new bit enters at the bottom
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hdr_q <= '0;
        end else if (frame_en) begin
            hdr_q.raw <= {hdr_q.raw[CTRL_BITS-2:0], control};
        end
    end

    // held after the last bit for decode and the whole transfer
    assign hdr = hdr_q;

endmodule

`default_nettype wire

//--- rtl/sbus_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_bit_timer (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic cnt_en,
    input  wire logic cnt_clr,
    output logic      frame_done,
    output logic      word_done
);

    import sbus_pkg::*;

    logic [CNT_WIDTH-1:0] cnt;

    // clear wins over enable
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cnt <= '0;
        end else if (cnt_clr) begin
            cnt <= '0;
        end else if (cnt_en) begin
            cnt <= cnt + 1'b1;
        end
    end

    // flags mark the cycle that carries the final bit
    assign frame_done = (cnt == CNT_WIDTH'(CTRL_BITS - 1));
    assign word_done  = (cnt == CNT_WIDTH'(DATA_WIDTH - 1));

endmodule

`default_nettype wire

//--- rtl/sbus_slave_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_slave_fsm #(
    parameter logic [sbus_pkg::SID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                control,
    input  wire logic                valid,
    input  wire logic                last,
    input  wire sbus_pkg::sbus_hdr_t hdr,
    input  wire logic                frame_done,
    input  wire logic                word_done,
    output logic                     frame_en,
    output logic                     cnt_en,
    output logic                     cnt_clr,
    output sbus_pkg::sbus_dp_ctrl_t  dp,
    output logic                     ready
);

    import sbus_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FRAME,
        S_DECODE,
        S_FETCH,
        S_SEND,
        S_WRITE,
        S_DONE
    } state_t;

    state_t                state;
    state_t                state_nxt;
    logic [ADDR_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] addr_nxt;
    logic                  last_q;
    logic                  last_nxt;
    logic                  hdr_ok;

    assign hdr_ok = (hdr.f.start == START_PATTERN) && (hdr.f.sid == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state  <= S_IDLE;
            addr   <= '0;
            last_q <= 1'b0;
        end else begin
            state  <= state_nxt;
            addr   <= addr_nxt;
            last_q <= last_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        addr_nxt  = addr;
        last_nxt  = last_q;
        frame_en  = 1'b0;
        cnt_en    = 1'b0;
        cnt_clr   = 1'b0;
        ready     = 1'b0;
        dp        = '0;
        dp.addr   = addr;
        case (state)
            S_IDLE: begin
                // the first high control bit is already frame bit one
                ready    = 1'b1;
                frame_en = control;
                cnt_en   = control;
                cnt_clr  = !control;
                if (control) begin
                    state_nxt = S_FRAME;
                end
            end
            S_FRAME: begin
                ready    = 1'b1;
                frame_en = 1'b1;
                cnt_en   = 1'b1;
                if (frame_done) begin
                    cnt_clr   = 1'b1;
                    state_nxt = S_DECODE;
                end
            end
            S_DECODE: begin
                // memory sees the header address now, word ready in fetch
                dp.addr  = hdr.f.addr;
                addr_nxt = hdr.f.addr;
                last_nxt = 1'b0;
                if (!hdr_ok) begin
                    state_nxt = S_IDLE;
                end else if (hdr.f.write) begin
                    state_nxt = S_WRITE;
                end else begin
                    state_nxt = S_FETCH;
                end
            end
            S_FETCH: begin
                dp.load_rd = 1'b1;
                state_nxt  = S_SEND;
            end
            S_SEND: begin
                // no pause inside a read word
                ready       = 1'b1;
                dp.shift_rd = 1'b1;
                cnt_en      = 1'b1;
                if (word_done) begin
                    cnt_clr = 1'b1;
                    if (hdr.f.burst && !last) begin
                        addr_nxt  = addr + 1'b1;
                        state_nxt = S_DONE;
                    end else begin
                        state_nxt = S_IDLE;
                    end
                end
            end
            S_WRITE: begin
                // valid low holds the count, master back-pressure
                ready       = 1'b1;
                dp.shift_wr = valid;
                cnt_en      = valid;
                if (valid && word_done) begin
                    cnt_clr   = 1'b1;
                    last_nxt  = last;
                    state_nxt = S_DONE;
                end
            end
            S_DONE: begin
                // store a write word, or fetch the next read word
                dp.mem_we = hdr.f.write;
                if (!hdr.f.write) begin
                    state_nxt = S_FETCH;
                end else if (hdr.f.burst && !last_q) begin
                    addr_nxt  = addr + 1'b1;
                    state_nxt = S_WRITE;
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/sbus_data_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_data_shifter (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire sbus_pkg::sbus_dp_ctrl_t        ctrl,
    input  wire logic                           wd,
    input  wire logic [sbus_pkg::DATA_WIDTH-1:0] rdata,
    output logic                                rd,
    output logic [sbus_pkg::DATA_WIDTH-1:0]     wr_word
);

    import sbus_pkg::*;

    logic [DATA_WIDTH-1:0] rd_reg;
    logic [DATA_WIDTH-1:0] wr_reg;

    // read side, parallel in and serial out from the top
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rd_reg <= '0;
        end else if (ctrl.load_rd) begin
            rd_reg <= rdata;
        end else if (ctrl.shift_rd) begin
            rd_reg <= {rd_reg[DATA_WIDTH-2:0], 1'b0};
        end
    end

    // zeros fill in behind, so rd falls back low after a word
    assign rd = rd_reg[DATA_WIDTH-1];

    // write side, first bit received ends up as the msb
    always_ff @(posedge clk) begin
        if (ctrl.shift_wr) begin
            wr_reg <= {wr_reg[DATA_WIDTH-2:0], wd};
        end
    end

    assign wr_word = wr_reg;

endmodule

`default_nettype wire

//--- rtl/sbus_slave_mem.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_slave_mem (
    input  wire logic                            clk,
    input  wire sbus_pkg::sbus_dp_ctrl_t         ctrl,
    input  wire logic [sbus_pkg::DATA_WIDTH-1:0] wdata,
    output logic [sbus_pkg::DATA_WIDTH-1:0]      rdata
);

    import sbus_pkg::*;

    logic [DATA_WIDTH-1:0] ram [ADDR_DEPTH];

    // single port, read data registered one cycle after the address
    always_ff @(posedge clk) begin
        if (ctrl.mem_we) begin
            ram[ctrl.addr] <= wdata;
        end
        rdata <= ram[ctrl.addr];
    end

endmodule

`default_nettype wire

//--- rtl/sbus_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sbus_slave #(
    parameter logic [sbus_pkg::SID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic control,
    input  wire logic wd,
    input  wire logic valid,
    input  wire logic last,
    output logic      rd,
    output logic      ready
);

    import sbus_pkg::*;

    sbus_hdr_t             hdr;
    sbus_dp_ctrl_t         dp;
    logic                  frame_en;
    logic                  cnt_en;
    logic                  cnt_clr;
    logic                  frame_done;
    logic                  word_done;
    logic [DATA_WIDTH-1:0] rdata;
    logic [DATA_WIDTH-1:0] wr_word;

    sbus_frame_rx u_frame_rx (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .frame_en (frame_en),
        .hdr      (hdr)
    );

    sbus_bit_timer u_bit_timer (
        .clk        (clk),
        .rstN       (rstN),
        .cnt_en     (cnt_en),
        .cnt_clr    (cnt_clr),
        .frame_done (frame_done),
        .word_done  (word_done)
    );

    sbus_slave_fsm #(
        .SLAVE_ID (SLAVE_ID)
    ) u_fsm (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .valid      (valid),
        .last       (last),
        .hdr        (hdr),
        .frame_done (frame_done),
        .word_done  (word_done),
        .frame_en   (frame_en),
        .cnt_en     (cnt_en),
        .cnt_clr    (cnt_clr),
        .dp         (dp),
        .ready      (ready)
    );

    sbus_data_shifter u_shifter (
        .clk     (clk),
        .rstN    (rstN),
        .ctrl    (dp),
        .wd      (wd),
        .rdata   (rdata),
        .rd      (rd),
        .wr_word (wr_word)
    );

    sbus_slave_mem u_mem (
        .clk   (clk),
        .ctrl  (dp),
        .wdata (wr_word),
        .rdata (rdata)
    );

endmodule

`default_nettype wire

//--- tests/tb_sbus_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sbus_slave;

    import sbus_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam logic [SID_WIDTH-1:0] SLAVE_ID = 2'd1;
    localparam int N_OPS = 15;
    localparam int TIMEOUT_CYCLES = N_OPS * (CTRL_BITS + 4 * DATA_WIDTH + 40);

    // one table row holds a frame and the words that go with it
    typedef struct packed {
        logic                       is_write;
        logic [SID_WIDTH-1:0]       sid;
        logic [2:0]                 start;
        logic                       burst;
        logic [ADDR_WIDTH-1:0]      addr;
        logic [2:0]                 count;
        logic [3:0][DATA_WIDTH-1:0] data;
    } op_t;

    logic clk;
    logic rstN;
    logic control;
    logic wd;
    logic valid;
    logic last;
    logic rd;
    logic ready;

    op_t                   ops [N_OPS];
    logic [DATA_WIDTH-1:0] model [ADDR_DEPTH];
    integer                seed;
    int                    errors;
    int                    tests_failed;

    sbus_slave #(
        .SLAVE_ID (SLAVE_ID)
    ) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wd      (wd),
        .valid   (valid),
        .last    (last),
        .rd      (rd),
        .ready   (ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic op_t build_op(input logic is_write, input logic [1:0] sid,
                                     input logic [2:0] start, input logic burst,
                                     input logic [10:0] addr, input int count,
                                     input logic [31:0] d0, input logic [31:0] d1,
                                     input logic [31:0] d2, input logic [31:0] d3);
        op_t op;
        op.is_write = is_write;
        op.sid      = sid;
        op.start    = start;
        op.burst    = burst;
        op.addr     = addr;
        op.count    = 3'(count);
        op.data     = {d3, d2, d1, d0};
        return op;
    endfunction

    task automatic fill_table();
        ops[0]  = build_op(1'b1, 2'd1, 3'b111, 1'b0, 11'd5, 1, 32'hdeadbeef, '0, '0, '0);
        ops[1]  = build_op(1'b0, 2'd1, 3'b111, 1'b0, 11'd5, 1, '0, '0, '0, '0);
        ops[2]  = build_op(1'b1, 2'd1, 3'b111, 1'b1, 11'd100, 4, 32'h01234567,
                           32'h89abcdef, 32'ha5a5a5a5, 32'h5a5a5a5a);
        ops[3]  = build_op(1'b0, 2'd1, 3'b111, 1'b1, 11'd100, 4, '0, '0, '0, '0);
        // other slave id, then a broken start pattern
        ops[4]  = build_op(1'b1, 2'd2, 3'b111, 1'b0, 11'd5, 1, 32'h12345678, '0, '0, '0);
        ops[5]  = build_op(1'b1, 2'd1, 3'b101, 1'b1, 11'd100, 4, 32'hffffffff,
                           32'hffffffff, 32'hffffffff, 32'hffffffff);
        ops[6]  = build_op(1'b0, 2'd1, 3'b111, 1'b0, 11'd5, 1, '0, '0, '0, '0);
        ops[7]  = build_op(1'b0, 2'd1, 3'b111, 1'b1, 11'd100, 4, '0, '0, '0, '0);
        // top address minus three
        ops[8]  = build_op(1'b1, 2'd1, 3'b111, 1'b1, 11'd1996, 4, 32'hc0ffee00,
                           32'h0badf00d, 32'h13579bdf, 32'h2468ace0);
        ops[9]  = build_op(1'b0, 2'd1, 3'b111, 1'b1, 11'd1996, 4, '0, '0, '0, '0);
        ops[10] = build_op(1'b1, 2'd1, 3'b111, 1'b1, 11'd0, 3, 32'h00000001,
                           32'h80000000, 32'h7fffffff, '0);
        ops[11] = build_op(1'b0, 2'd1, 3'b111, 1'b1, 11'd1, 2, '0, '0, '0, '0);
        ops[12] = build_op(1'b1, 2'd1, 3'b111, 1'b0, 11'd101, 1, 32'hfeedface, '0, '0, '0);
        ops[13] = build_op(1'b0, 2'd1, 3'b111, 1'b1, 11'd100, 4, '0, '0, '0, '0);
        ops[14] = build_op(1'b0, 2'd3, 3'b111, 1'b0, 11'd5, 1, '0, '0, '0, '0);
    endtask

    // msb first, one bit per cycle, control low again afterwards
    task automatic send_frame(input logic [CTRL_BITS-1:0] frame);
        for (int i = CTRL_BITS - 1; i >= 0; i--) begin
            @(posedge clk);
            #2;
            control = frame[i];
        end
        @(posedge clk);
        #2;
        control = 1'b0;
    endtask

    task automatic write_words(input op_t op);
        int w;
        int b;
        logic sent;
        w = 0;
        b = DATA_WIDTH - 1;
        while (w < int'(op.count)) begin
            // last only closes a burst
            last = op.burst && (w == int'(op.count) - 1);
            // roughly one cycle in eight held back with valid low
            sent = ready && (($random(seed) & 7) != 0);
            valid = sent;
            wd = sent ? op.data[w][b] : 1'b0;
            @(posedge clk);
            #2;
            if (sent) begin
                if (b == 0) begin
                    w++;
                    b = DATA_WIDTH - 1;
                end else begin
                    b--;
                end
            end
        end
        valid = 1'b0;
        wd = 1'b0;
        last = 1'b0;
    endtask

    task automatic read_words(input op_t op);
        int w;
        int b;
        int gap;
        logic [DATA_WIDTH-1:0] got;
        w = 0;
        b = DATA_WIDTH - 1;
        gap = 0;
        got = '0;
        while (w < int'(op.count)) begin
            last = op.burst && (w == int'(op.count) - 1);
            if (ready) begin
                // decode plus fetch, or fetch plus load between words, none inside a word
                check_val("ready low cycles", 32'(gap),
                          (b == DATA_WIDTH - 1) ? 32'd2 : 32'd0);
                gap = 0;
                got[b] = rd;
                if (b == 0) begin
                    check_val("rd", got, model[int'(op.addr) + w]);
                    w++;
                    b = DATA_WIDTH - 1;
                end else begin
                    b--;
                end
            end else begin
                gap++;
            end
            @(posedge clk);
            #2;
        end
        last = 1'b0;
    endtask

    task automatic run_op(input int idx);
        op_t op;
        logic accepted;
        int errs_before;
        op = ops[idx];
        accepted = (op.start == 3'b111) && (op.sid == SLAVE_ID);
        errs_before = errors;
        send_frame({op.start, op.sid, op.is_write, op.burst, op.addr});
        check_val("ready", 32'(ready), 32'd0);
        if (op.is_write) begin
            // the master sends its words whether or not the frame is ours
            write_words(op);
            if (accepted) begin
                for (int i = 0; i < int'(op.count); i++) begin
                    model[int'(op.addr) + i] = op.data[i];
                end
            end
        end else if (accepted) begin
            read_words(op);
        end
        // back in idle
        @(posedge clk);
        #2;
        check_val("ready", 32'(ready), 32'd1);
        check_val("rd", 32'(rd), 32'd0);
        if (errors != errs_before) begin
            tests_failed++;
        end
        $display("test %0d %s addr %0d words %0d: %s", idx + 1,
                 !accepted ? "ignored frame" : (op.is_write ? "write" : "read"),
                 op.addr, op.count, (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        seed = 69;
        errors = 0;
        tests_failed = 0;
        rstN = 1'b0;
        control = 1'b0;
        wd = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        check_val("ready", 32'(ready), 32'd1);
        check_val("rd", 32'(rd), 32'd0);
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test 0 reset: %s", (errors == 0) ? "ok" : "mismatch");
        for (int i = 0; i < N_OPS; i++) begin
            run_op(i);
        end
        $display("%0d tests, %0d failed, %0d errors", N_OPS + 1, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // worst case per row is a frame and four words with gaps
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sbus_slave.f
rtl/sbus_pkg.sv
rtl/sbus_frame_rx.sv
rtl/sbus_bit_timer.sv
rtl/sbus_slave_fsm.sv
rtl/sbus_data_shifter.sv
rtl/sbus_slave_mem.sv
rtl/sbus_slave.sv
tests/tb_sbus_slave.sv

//--- Makefile
TOP  := tb_sbus_slave
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat sbus_slave.f)

.PHONY: all run clean

all: run

$(SIM): sbus_slave.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sbus_slave.f

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
